// ==== fpMulPkg.sv ====
`default_nettype none

package fpMulPkg;

	// Half precision format
	localparam int expWidth = 5;
	localparam int fracWidth = 10;
	localparam int expBias = 15;
	localparam int expMax = 31;               // All-ones exponent
	localparam int sigWidth = fracWidth + 1;  // With hidden one
	localparam int prodWidth = 2 * sigWidth;  // Full significand product

	localparam logic [15:0] qNaN = 16'h7E00;  // Canonical quiet NaN

	// Field view of one half word
	typedef struct packed {
		logic                 sign;
		logic [expWidth-1:0]  exp;
		logic [fracWidth-1:0] frac;
	} fp16FieldsT;

	// Same 16 bits, raw or split into fields
	typedef union packed {
		logic [15:0] raw;
		fp16FieldsT  fields;
	} fp16T;

	// Special class of the operand pair
	typedef struct packed {
		logic isNaN;    // Either input NaN
		logic isInf;    // Either input infinite
		logic isZero;   // Either input zero or subnormal
		logic invalid;  // Inf times zero, or signalling NaN
	} excT;

	// Stage 1 to stage 2
	typedef struct packed {
		logic                  sign;
		logic signed [7:0]     expSum;    // Biased, before normalization
		logic [prodWidth-1:0]  mantProd;
		excT                   exc;
	} prepT;

	// Stage 2 to stage 3
	typedef struct packed {
		logic                 sign;
		logic signed [7:0]    exp;
		logic [sigWidth-1:0]  mant;      // Hidden bit at MSB
		logic                 guard;
		logic                 sticky;
		excT                  exc;
	} normT;

	// Result flags
	typedef struct packed {
		logic invalid;
		logic overflow;
		logic underflow;
		logic inexact;
	} fpFlagsT;

endpackage

`default_nettype wire

// ==== fpMulPrep.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpMulPrep (
	input  logic            clk,
	input  logic            rstN,
	input  logic            inValid,
	input  fpMulPkg::fp16T  a,
	input  fpMulPkg::fp16T  b,
	output logic            prepValid,
	output fpMulPkg::prepT  prep
);
	import fpMulPkg::*;

	logic aZero;
	logic bZero;
	logic aMaxExp;
	logic bMaxExp;
	logic aInf;
	logic bInf;
	logic aNaN;
	logic bNaN;
	logic aSNaN;
	logic bSNaN;
	logic [sigWidth-1:0] aSig;
	logic [sigWidth-1:0] bSig;
	logic signed [7:0] expSumNext;
	excT excNext;

	// Exponent zero covers subnormals too, flushed to zero
	assign aZero = (a.fields.exp == '0);
	assign bZero = (b.fields.exp == '0);

	assign aMaxExp = (a.fields.exp == expWidth'(expMax));
	assign bMaxExp = (b.fields.exp == expWidth'(expMax));

	// Inf needs zero fraction, NaN needs non-zero fraction
	assign aInf = aMaxExp && (a.fields.frac == '0);
	assign bInf = bMaxExp && (b.fields.frac == '0);
	assign aNaN = aMaxExp && (a.fields.frac != '0);
	assign bNaN = bMaxExp && (b.fields.frac != '0);

	// Quiet bit clear means signalling
	assign aSNaN = aNaN && !a.fields.frac[fracWidth-1];
	assign bSNaN = bNaN && !b.fields.frac[fracWidth-1];

	always_comb begin
		excNext.isNaN   = aNaN | bNaN;
		excNext.isInf   = aInf | bInf;
		excNext.isZero  = aZero | bZero;
		// Inf x 0 in either order, or any sNaN
		excNext.invalid = (aInf & bZero) | (bInf & aZero) | aSNaN | bSNaN;
	end

	// Hidden ones restored
	assign aSig = {1'b1, a.fields.frac};
	assign bSig = {1'b1, b.fields.frac};

	// ea + eb - bias, range -15..47
	assign expSumNext = 8'(a.fields.exp) + 8'(b.fields.exp) - 8'(expBias);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			prepValid <= 1'b0;
		end else begin
			prepValid <= inValid;
		end
	end

	// Payload only loads with a valid pair
	always_ff @(posedge clk) begin
		if (inValid) begin
			prep.sign     <= a.fields.sign ^ b.fields.sign;
			prep.expSum   <= expSumNext;
			prep.mantProd <= aSig * bSig;  // 11 x 11 -> 22
			prep.exc      <= excNext;
		end
	end

endmodule

`default_nettype wire

// ==== fpMulNorm.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpMulNorm (
	input  logic            clk,
	input  logic            rstN,
	input  logic            prepValid,
	input  fpMulPkg::prepT  prep,
	output logic            normValid,
	output fpMulPkg::normT  norm
);
	import fpMulPkg::*;

	localparam int guardPos = prodWidth - sigWidth - 1;  // Bit just below the kept field

	logic                  prodHigh;
	logic [prodWidth-1:0]  prodAligned;
	logic [sigWidth-1:0]   mantNext;
	logic                  guardNext;
	logic                  stickyNext;
	logic signed [7:0]     expNext;

	// Product of two [1,2) values lies in [1,4)
	assign prodHigh = prep.mantProd[prodWidth-1];

	always_comb begin
		if (prodHigh) begin
			prodAligned = prep.mantProd;
			expNext     = prep.expSum + 8'sd1;  // Product in [2,4)
		end else begin
			prodAligned = prep.mantProd << 1;  // Leading one into MSB
			expNext     = prep.expSum;
		end
	end

	// Top 11 bits kept, then guard, rest folded to sticky
	assign mantNext   = prodAligned[prodWidth-1 -: sigWidth];
	assign guardNext  = prodAligned[guardPos];
	assign stickyNext = |prodAligned[guardPos-1:0];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			normValid <= 1'b0;
		end else begin
			normValid <= prepValid;
		end
	end

	always_ff @(posedge clk) begin
		if (prepValid) begin
			norm.sign   <= prep.sign;
			norm.exp    <= expNext;
			norm.mant   <= mantNext;
			norm.guard  <= guardNext;
			norm.sticky <= stickyNext;
			norm.exc    <= prep.exc;   // Class rides along untouched
		end
	end

endmodule

`default_nettype wire

// ==== fpMulRound.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpMulRound (
	input  logic               clk,
	input  logic               rstN,
	input  logic               normValid,
	input  fpMulPkg::normT     norm,
	output logic               outValid,
	output fpMulPkg::fp16T     result,
	output fpMulPkg::fpFlagsT  flags
);
	import fpMulPkg::*;

	logic                 roundUp;
	logic [sigWidth:0]    mantRnd;   // One extra bit for carry
	logic [sigWidth-1:0]  mantFin;
	logic signed [7:0]    expFin;
	logic                 lost;
	fp16T                 resNext;
	fpFlagsT              flagsNext;

	// Nearest even, ties go to even LSB
	assign roundUp = norm.guard & (norm.sticky | norm.mant[0]);
	assign mantRnd = {1'b0, norm.mant} + (sigWidth+1)'(roundUp);
	assign lost    = norm.guard | norm.sticky;

	always_comb begin
		if (mantRnd[sigWidth]) begin
			mantFin = mantRnd[sigWidth:1];  // 1.111.. rolled to 10.000..
			expFin  = norm.exp + 8'sd1;
		end else begin
			mantFin = mantRnd[sigWidth-1:0];
			expFin  = norm.exp;
		end
	end

	always_comb begin
		resNext.raw = '0;
		flagsNext   = '0;
		if (norm.exc.isNaN || norm.exc.invalid) begin
			resNext.raw       = qNaN;
			flagsNext.invalid = norm.exc.invalid;  // Only Inf x 0 or sNaN
		end else if (norm.exc.isInf) begin
			resNext.fields.sign = norm.sign;   // Inf x finite non-zero
			resNext.fields.exp  = expWidth'(expMax);
		end else if (norm.exc.isZero) begin
			resNext.fields.sign = norm.sign;   // Exact signed zero
		end else if (expFin >= expMax) begin
			// Too large, saturate to infinity
			resNext.fields.sign = norm.sign;
			resNext.fields.exp  = expWidth'(expMax);
			flagsNext.overflow  = 1'b1;
			flagsNext.inexact   = 1'b1;
		end else if (expFin <= 0) begin
			resNext.fields.sign = norm.sign;   // Flush, no subnormal out
			flagsNext.underflow = 1'b1;
			flagsNext.inexact   = 1'b1;
		end else begin
			resNext.fields.sign = norm.sign;
			resNext.fields.exp  = expFin[expWidth-1:0];
			resNext.fields.frac = mantFin[fracWidth-1:0];  // Hidden bit dropped
			flagsNext.inexact   = lost;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= normValid;
		end
	end

	always_ff @(posedge clk) begin
		if (normValid) begin
			result <= resNext;
			flags  <= flagsNext;
		end
	end

	// Valid chain must be clean once out of reset
	aValidKnown: assert property (@(posedge clk) disable iff (!rstN)
		!$isunknown(outValid))
		else $error("outValid unknown after reset");

	// Invalid only ever paired with canonical NaN
	aInvalidNaN: assert property (@(posedge clk) disable iff (!rstN)
		(outValid && flags.invalid) |-> (result.raw == qNaN))
		else $error("invalid flag without qNaN result");

	// Overflow always saturates to infinity
	aOverflowInf: assert property (@(posedge clk) disable iff (!rstN)
		(outValid && flags.overflow) |->
		(result.fields.exp == expWidth'(expMax) && result.fields.frac == '0))
		else $error("overflow flag without infinity result");

endmodule

`default_nettype wire

// ==== fpMul.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpMul (
	input  logic               clk,
	input  logic               rstN,
	input  logic               inValid,
	input  fpMulPkg::fp16T     a,
	input  fpMulPkg::fp16T     b,
	output logic               outValid,
	output fpMulPkg::fp16T     result,
	output fpMulPkg::fpFlagsT  flags
);
	import fpMulPkg::*;

	logic prepValid;   // Stage 1 done
	prepT prep;
	logic normValid;   // Stage 2 done
	normT norm;

	// Decode, sign, exponent sum, significand product
	fpMulPrep prepStage (
		.clk       (clk),
		.rstN      (rstN),
		.inValid   (inValid),
		.a         (a),
		.b         (b),
		.prepValid (prepValid),
		.prep      (prep)
	);

	// One place shift, guard and sticky
	fpMulNorm normStage (
		.clk       (clk),
		.rstN      (rstN),
		.prepValid (prepValid),
		.prep      (prep),
		.normValid (normValid),
		.norm      (norm)
	);

	// RNE, range checks, specials, pack
	fpMulRound roundStage (
		.clk       (clk),
		.rstN      (rstN),
		.normValid (normValid),
		.norm      (norm),
		.outValid  (outValid),
		.result    (result),
		.flags     (flags)
	);

endmodule

`default_nettype wire

// ==== fpMulModel.svh ====
`ifndef FP_MUL_MODEL_SVH
`define FP_MUL_MODEL_SVH

// Expected output of one multiply
typedef struct packed {
	fp16T    result;
	fpFlagsT flags;
} expectT;

logic [31:0] lcgState = 32'd2367;  // Fixed seed

// Plain 32-bit LCG, middle bits returned
function automatic logic [15:0] nextRand();
	lcgState = lcgState * 32'd1103515245 + 32'd12345;
	return lcgState[30:15];
endfunction

// Reference multiply written straight from the format rules
function automatic expectT mulModel(input logic [15:0] x, input logic [15:0] y);
	expectT      e;
	logic        sr;
	logic [4:0]  ex;
	logic [4:0]  ey;
	logic [9:0]  fx;
	logic [9:0]  fy;
	logic        nanX;
	logic        nanY;
	logic        infX;
	logic        infY;
	logic        zeroX;
	logic        zeroY;
	logic [21:0] prod;
	logic [21:0] kept;
	logic [21:0] rem;
	logic [21:0] half;
	int          shift;
	int          expo;
	e     = '0;
	sr    = x[15] ^ y[15];
	ex    = x[14:10];
	ey    = y[14:10];
	fx    = x[9:0];
	fy    = y[9:0];
	nanX  = (ex == 5'(expMax)) && (fx != '0);
	nanY  = (ey == 5'(expMax)) && (fy != '0);
	infX  = (ex == 5'(expMax)) && (fx == '0);
	infY  = (ey == 5'(expMax)) && (fy == '0);
	zeroX = (ex == '0);  // Subnormals count as zero
	zeroY = (ey == '0);
	if (nanX || nanY) begin
		e.result.raw   = qNaN;
		e.flags.invalid = (nanX && !fx[9]) || (nanY && !fy[9]);  // Signalling only
	end else if ((infX && zeroY) || (infY && zeroX)) begin
		e.result.raw    = qNaN;
		e.flags.invalid = 1'b1;
	end else if (infX || infY) begin
		e.result.raw = {sr, 5'(expMax), 10'h000};
	end else if (zeroX || zeroY) begin
		e.result.raw = {sr, 15'h0000};
	end else begin
		prod  = {1'b1, fx} * {1'b1, fy};
		shift = prod[21] ? 11 : 10;     // Bits below the 11-bit significand
		expo  = int'(ex) + int'(ey) - expBias + (shift - 10);
		kept  = prod >> shift;
		rem   = prod & ((22'd1 << shift) - 22'd1);
		half  = 22'd1 << (shift - 1);
		// Above half rounds up, exact half goes to even
		if ((rem > half) || ((rem == half) && kept[0])) kept = kept + 22'd1;
		if (kept == 22'd2048) begin
			kept = kept >> 1;
			expo = expo + 1;
		end
		if (expo >= expMax) begin
			e.result.raw     = {sr, 5'(expMax), 10'h000};
			e.flags.overflow = 1'b1;
			e.flags.inexact  = 1'b1;
		end else if (expo <= 0) begin
			e.result.raw      = {sr, 15'h0000};  // Flushed
			e.flags.underflow = 1'b1;
			e.flags.inexact   = 1'b1;
		end else begin
			e.result.raw    = {sr, expo[4:0], kept[9:0]};
			e.flags.inexact = (rem != '0);
		end
	end
	return e;
endfunction

`endif

// ==== fpMulTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpMulTb;
	import fpMulPkg::*;

	localparam int timeoutCycles = 1500;  // Roughly four times the full test length

	logic    clk;
	logic    rstN;
	logic    inValid;
	fp16T    a;
	fp16T    b;
	logic    outValid;
	fp16T    result;
	fpFlagsT flags;

	int cycleCount = 0;

	`include "fpMulModel.svh"

	expectT expQ[$];  // Expectations in flight with the oldest first

	fpMul DUT (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.a        (a),
		.b        (b),
		.outValid (outValid),
		.result   (result),
		.flags    (flags)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == timeoutCycles) begin
			$display("Run stopped, test did not finish within %0d cycles", timeoutCycles);
			$display("** FAIL **");
			$fatal(1, "Timeout");
		end
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("** Error %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("** FAIL **");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Results sampled on the falling edge
	always @(negedge clk) begin : monitor
		expectT want;
		if (outValid === 1'b1) begin
			if (expQ.size() == 0) begin
				$display("outValid was high while no result was expected");
				$display("** FAIL **");
				$fatal(1, "Unexpected result");
			end else begin
				want = expQ.pop_front();
				checkValue("result", result.raw, want.result.raw);
				checkValue("flags", flags, want.flags);
			end
		end
	end

	// One pair per call and one call per cycle
	task automatic drivePair(input logic [15:0] x, input logic [15:0] y);
		@(posedge clk);
		inValid <= 1'b1;
		a.raw   <= x;
		b.raw   <= y;
		expQ.push_back(mulModel(x, y));
	endtask

	// Hand-worked value also checked against the model
	task automatic expectPair(input logic [15:0] x, input logic [15:0] y,
			input logic [15:0] wantRes, input logic [3:0] wantFlags);
		expectT predicted;
		predicted = mulModel(x, y);
		checkValue("model result", predicted.result.raw, wantRes);
		checkValue("model flags", predicted.flags, wantFlags);
		drivePair(x, y);
	endtask

	task automatic stopInput();
		@(posedge clk);
		inValid <= 1'b0;
	endtask

	task automatic drain();
		while (expQ.size() != 0) @(negedge clk);
		@(negedge clk);
	endtask

	task automatic idleCheck(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			checkValue("outValid", outValid, 1'b0);
		end
	endtask

	task automatic latencyTest();
		int waitCycles;
		idleCheck(3);  // Nothing before first input
		expectPair(16'h3C00, 16'h4000, 16'h4000, 4'b0000);
		stopInput();   // Edge that samples the pair
		waitCycles = 0;
		do begin
			@(negedge clk);
			waitCycles++;
		end while (!outValid && waitCycles < 8);
		checkValue("latency", waitCycles, 3);
		idleCheck(4);  // Exactly one result per pair
	endtask

	task automatic exactTest();
		expectPair(16'h3E00, 16'h4000, 16'h4200, 4'b0000);  // 1.5 x 2
		expectPair(16'hC200, 16'h3800, 16'hBE00, 4'b0000);  // -3 x 0.5
		expectPair(16'h3C00, 16'h5555, 16'h5555, 4'b0000);  // 1 x x
		expectPair(16'hBC00, 16'h1234, 16'h9234, 4'b0000);
		stopInput();
		drain();
	endtask

	task automatic roundingTest();
		expectPair(16'h3C01, 16'h3D00, 16'h3D01, 4'b0001);  // Below half
		expectPair(16'h3E00, 16'h3C03, 16'h3E04, 4'b0001);  // Half, even kept
		expectPair(16'h3C01, 16'h3E00, 16'h3E02, 4'b0001);  // Half, odd rounds up
		expectPair(16'h3C01, 16'h3F00, 16'h3F02, 4'b0001);  // Above half
		expectPair(16'h3DA8, 16'h3DA8, 16'h4000, 4'b0001);  // Carry into exponent
		stopInput();
		drain();
	endtask

	task automatic specialTest();
		expectPair(16'h7E01, 16'h3C00, 16'h7E00, 4'b0000);  // Quiet NaN
		expectPair(16'h4000, 16'h7C01, 16'h7E00, 4'b1000);  // Signalling NaN
		expectPair(16'h7C00, 16'h0000, 16'h7E00, 4'b1000);
		expectPair(16'h8000, 16'hFC00, 16'h7E00, 4'b1000);
		expectPair(16'h0200, 16'h7C00, 16'h7E00, 4'b1000);  // Subnormal is zero here too
		expectPair(16'h7C00, 16'hC000, 16'hFC00, 4'b0000);
		expectPair(16'h0001, 16'h4000, 16'h0000, 4'b0000);
		expectPair(16'h83FF, 16'h3C00, 16'h8000, 4'b0000);
		expectPair(16'h7BFF, 16'h7BFF, 16'h7C00, 4'b0101);  // Max x max
		expectPair(16'h7800, 16'hC000, 16'hFC00, 4'b0101);
		expectPair(16'h0400, 16'h3800, 16'h0000, 4'b0011);  // Min normal x 0.5
		expectPair(16'h8400, 16'h0400, 16'h8000, 4'b0011);
		stopInput();
		drain();
	endtask

	task automatic randomTest();
		repeat (200) drivePair(nextRand(), nextRand());  // Pipeline kept full
		stopInput();
		drain();
	endtask

	task automatic midResetTest();
		repeat (3) drivePair(nextRand(), nextRand());
		@(posedge clk);
		rstN    <= 1'b0;
		inValid <= 1'b0;
		@(posedge clk);  // Reset taken here
		checkValue("inFlight", expQ.size(), 2);  // Oldest item already out
		expQ.delete();
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
		idleCheck(5);
		expectPair(16'h3E00, 16'h3E00, 16'h4080, 4'b0000);  // 1.5 x 1.5
		repeat (4) drivePair(nextRand(), nextRand());
		stopInput();
		drain();
	endtask

	initial begin
		rstN    = 1'b0;
		inValid = 1'b0;
		a       = '0;
		b       = '0;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;
		latencyTest();
		exactTest();
		roundingTest();
		specialTest();
		randomTest();
		midResetTest();
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
fpMulPkg.sv
fpMulPrep.sv
fpMulNorm.sv
fpMulRound.sv
fpMul.sv
fpMulTb.sv
